// ==== list.f ====
+incdir+src
src/rrag_pkg.sv
src/pend_regfile.sv
src/addr_gen.sv
src/rrag_ctrl.sv
src/rrag_top.sv
sim/rrag_chk.sv
sim/rrag_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= rrag_tb
RTL_TOP   ?= rrag_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/rrag_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rrag_defines.svh"

module rrag_tb;

    import rrag_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 300;  // Longest test is 40 micro-ops
    localparam int STALL_LIMIT     = 20;

    logic  clk;
    logic  reset;
    logic  in_valid;
    logic  hold;
    uop_t  uop;
    wb_t   wb;
    logic  stall;
    logic  out_valid;
    agen_t out;

    logic [`RRAG_ADDR_W-1:0] gpr_m [`RRAG_NUM_GPR];  // Values written back so far
    logic [15:0]             sel_m [`RRAG_NUM_SEG];
    logic [`RRAG_LIM_W-1:0]  lim_m [`RRAG_NUM_SEG];
    logic [15:0]             lfsr;
    int                      errors;
    int                      checks;

    rrag_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .hold      (hold),
        .uop       (uop),
        .wb        (wb),
        .stall     (stall),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    // ********************
    // Model and helpers
    // ********************

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hb400;  // Galois taps 16,14,13,11
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic uop_t mk_uop(input logic ub, input reg_idx_t br, input logic ui,
                                    input reg_idx_t ir, input logic [1:0] sc,
                                    input reg_idx_t sr, input logic [31:0] disp,
                                    input opsize_t sz);
        uop_t u;
        u           = '0;
        u.use_base  = ub;
        u.base_reg  = br;
        u.use_index = ui;
        u.index_reg = ir;
        u.scale     = sc;
        u.seg_reg   = sr;
        u.mem_use   = 1'b1;
        u.disp      = disp;
        u.opsize    = sz;
        return u;
    endfunction

    function automatic agen_t model_agen(input uop_t u);
        agen_t       e;
        logic [31:0] offset;
        logic [31:0] size;
        offset = u.disp;
        if (u.use_base) begin
            offset = offset + gpr_m[u.base_reg];
        end
        if (u.use_index) begin
            offset = offset + gpr_m[u.index_reg] * (32'd1 << u.scale);
        end
        size           = 32'd1 << u.opsize;
        e              = '0;
        e.mem_addr     = offset + {sel_m[u.seg_reg], 16'd0};
        e.mem_addr_end = e.mem_addr + size - 32'd1;
        e.lim_fault    = u.mem_use && (offset + size - 32'd1 > {12'd0, lim_m[u.seg_reg]});
        e.mem_use      = u.mem_use;
        e.base_val     = gpr_m[u.base_reg];
        e.index_val    = gpr_m[u.index_reg];
        e.dest_reg     = u.dest_reg;
        e.dest_ld      = u.dest_ld;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_gpr(input reg_idx_t a, input logic [31:0] d);
        @(negedge clk);
        wb.gpr_ld   = 1'b1;
        wb.gpr_addr = a;
        wb.gpr_data = d;
        @(negedge clk);
        wb.gpr_ld   = 1'b0;
        gpr_m[a]    = d;
    endtask

    task automatic write_seg(input reg_idx_t a, input logic [15:0] s,
                             input logic [`RRAG_LIM_W-1:0] l);
        @(negedge clk);
        wb.seg_ld       = 1'b1;
        wb.seg_addr     = a;
        wb.seg_data.sel = s;
        wb.seg_data.lim = l;
        @(negedge clk);
        wb.seg_ld       = 1'b0;
        sel_m[a]        = s;
        lim_m[a]        = l;
    endtask

    task automatic drive_uop(input uop_t u);
        @(negedge clk);
        uop      = u;
        in_valid = 1'b1;
    endtask

    // Returns on the falling edge after the accepting rising edge
    task automatic wait_accept;
        int waited;
        waited = 0;
        #1;
        while (stall && waited < STALL_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        checks++;
        assert (!stall) else begin
            errors++;
            $display("Micro-op was never accepted, stall stayed high");
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic compare_out(input uop_t u);
        agen_t exp;
        exp = model_agen(u);
        check_val("out_valid", 32'(out_valid), 32'd1);
        check_val("out.mem_addr", out.mem_addr, exp.mem_addr);
        check_val("out.mem_addr_end", out.mem_addr_end, exp.mem_addr_end);
        check_val("out.lim_fault", 32'(out.lim_fault), 32'(exp.lim_fault));
        check_val("out.mem_use", 32'(out.mem_use), 32'(exp.mem_use));
        check_val("out.base_val", out.base_val, exp.base_val);
        check_val("out.index_val", out.index_val, exp.index_val);
        check_val("out.dest_reg", 32'(out.dest_reg), 32'(exp.dest_reg));
        check_val("out.dest_ld", 32'(out.dest_ld), 32'(exp.dest_ld));
    endtask

    task automatic issue_and_check(input uop_t u);
        drive_uop(u);
        wait_accept;
        compare_out(u);
    endtask

    // ********************
    // Tests
    // ********************

    task automatic test_addr_modes;
        for (int i = 0; i < `RRAG_NUM_GPR; i++) begin
            write_gpr(reg_idx_t'(i), 32'h0000_1111 * (i + 1));
        end
        for (int m = 0; m < 16; m++) begin
            issue_and_check(mk_uop(m[3], 3'd1, m[2], 3'd3, m[1:0], 3'd0, 32'h100, OPSIZE_4));
        end
    endtask

    task automatic test_size_limit;
        for (int sz = 0; sz < 4; sz++) begin
            issue_and_check(mk_uop(1'b1, 3'd4, 1'b0, 3'd0, 2'd0, 3'd0, 32'h18, opsize_t'(sz[1:0])));
        end
        write_seg(3'd2, 16'h0012, 20'h00fff);
        issue_and_check(mk_uop(1'b0, 3'd0, 1'b0, 3'd0, 2'd0, 3'd2, 32'hffc, OPSIZE_4));
        check_val("out.lim_fault", 32'(out.lim_fault), 32'd0);  // Last byte sits on the limit
        issue_and_check(mk_uop(1'b0, 3'd0, 1'b0, 3'd0, 2'd0, 3'd2, 32'hffd, OPSIZE_4));
        check_val("out.lim_fault", 32'(out.lim_fault), 32'd1);
    endtask

    task automatic test_pending;
        uop_t u;
        u          = mk_uop(1'b0, 3'd0, 1'b0, 3'd0, 2'd0, 3'd0, 32'h0, OPSIZE_1);
        u.mem_use  = 1'b0;
        u.dest_reg = 3'd5;
        u.dest_ld  = 1'b1;
        issue_and_check(u);
        u = mk_uop(1'b1, 3'd5, 1'b0, 3'd0, 2'd0, 3'd0, 32'h40, OPSIZE_2);
        drive_uop(u);
        repeat (3) begin
            #1;
            check_val("stall", 32'(stall), 32'd1);
            @(negedge clk);
        end
        wb.gpr_ld   = 1'b1;
        wb.gpr_addr = 3'd5;
        wb.gpr_data = 32'h1357_9bdf;
        #1;
        check_val("stall", 32'(stall), 32'd1);  // Clear lands at the next edge
        @(negedge clk);
        wb.gpr_ld = 1'b0;
        gpr_m[5]  = 32'h1357_9bdf;
        wait_accept;
        compare_out(u);
        check_val("out.base_val", out.base_val, 32'h1357_9bdf);
    endtask

    task automatic test_hold;
        uop_t  u;
        agen_t held;
        issue_and_check(mk_uop(1'b0, 3'd0, 1'b1, 3'd2, 2'd2, 3'd0, 32'h200, OPSIZE_4));
        u        = mk_uop(1'b1, 3'd7, 1'b1, 3'd6, 2'd1, 3'd0, 32'h300, OPSIZE_8);
        held     = out;
        hold     = 1'b1;
        uop      = u;
        in_valid = 1'b1;
        repeat (4) begin
            #1;
            check_val("stall", 32'(stall), 32'd1);
            @(negedge clk);
            check_val("out_valid", 32'(out_valid), 32'd1);
            checks++;
            assert (out === held) else begin
                errors++;
                $display("Mismatch out: got %h, expected %h", out, held);
            end
        end
        hold = 1'b0;
        wait_accept;
        compare_out(u);
    endtask

    task automatic test_random;
        uop_t        u;
        logic [31:0] r;
        for (int n = 0; n < 40; n++) begin
            r = draw_bits(16);
            u = mk_uop(r[11], r[2:0], r[12], r[5:3], r[10:9], r[8:6], draw_bits(32),
                       opsize_t'(r[15:14]));
            u.mem_use = r[13];
            issue_and_check(u);
        end
    endtask

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        hold     = 1'b0;
        uop      = '0;
        wb       = '0;
        errors   = 0;
        checks   = 0;
        lfsr     = 16'd37;
        for (int i = 0; i < `RRAG_NUM_GPR; i++) begin
            gpr_m[i] = '0;
        end
        for (int i = 0; i < `RRAG_NUM_SEG; i++) begin
            sel_m[i] = '0;
            lim_m[i] = `RRAG_RESET_LIM;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_addr_modes;
        test_size_limit;
        test_pending;
        test_hold;
        test_random;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/rrag_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module rrag_chk (
    input logic            clk,
    input logic            reset,
    input logic            hold,
    input logic            stall,
    input logic            out_valid,
    input rrag_pkg::agen_t out
);

    // ********************
    // Output register
    // ********************

    a_valid_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // Downstream hold freezes the whole output
    a_hold_freezes: assert property (@(posedge clk) disable iff (reset)
        (hold && out_valid) |=> ($stable(out) && out_valid))
        else $error("Output changed while hold was high");

    // ********************
    // Handshake
    // ********************

    a_no_stall_load: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(out))
        else $error("Output register loaded during a stall");

endmodule

bind rrag_top rrag_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .hold      (hold),
    .stall     (stall),
    .out_valid (out_valid),
    .out       (out)
);

`default_nettype wire

// ==== src/rrag_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rrag_defines.svh"

module rrag_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  logic            hold,
    input  rrag_pkg::uop_t  uop,
    input  rrag_pkg::wb_t   wb,
    output logic            stall,
    output logic            out_valid,
    output rrag_pkg::agen_t out
);

    import rrag_pkg::*;

    localparam seg_ent_t SEG_RST = '{sel: 16'h0000, lim: `RRAG_RESET_LIM};

    logic                    accept;
    logic                    gpr_mark;
    logic [`RRAG_ADDR_W-1:0] base_val;
    logic [`RRAG_ADDR_W-1:0] index_val;
    logic                    base_pend;
    logic                    index_pend;
    logic                    seg_pend;
    seg_ent_t                seg_val;

    assign gpr_mark = accept & uop.dest_ld;

    // ********************
    // Control
    // ********************

    rrag_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .hold       (hold),
        .uop        (uop),
        .base_pend  (base_pend),
        .index_pend (index_pend),
        .seg_pend   (seg_pend),
        .stall      (stall),
        .accept     (accept),
        .out_valid  (out_valid)
    );

    // ********************
    // Register files
    // ********************

    pend_regfile #(
        .NUM_ENT (`RRAG_NUM_GPR),
        .T       (logic [`RRAG_ADDR_W-1:0])
    ) u_gpr_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (uop.base_reg),
        .rd_addr_b (uop.index_reg),
        .rd_data_a (base_val),
        .rd_data_b (index_val),
        .rd_pend_a (base_pend),
        .rd_pend_b (index_pend),
        .wr_en     (wb.gpr_ld),
        .wr_addr   (wb.gpr_addr),
        .wr_data   (wb.gpr_data),
        .mark_en   (gpr_mark),
        .mark_addr (uop.dest_reg)
    );

    pend_regfile #(
        .NUM_ENT (`RRAG_NUM_SEG),
        .T       (seg_ent_t),
        .RST_VAL (SEG_RST)
    ) u_seg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (uop.seg_reg),
        .rd_addr_b (3'd0),
        .rd_data_a (seg_val),
        .rd_data_b (),
        .rd_pend_a (seg_pend),
        .rd_pend_b (),
        .wr_en     (wb.seg_ld),
        .wr_addr   (wb.seg_addr),
        .wr_data   (wb.seg_data),
        .mark_en   (1'b0),  // Segment loads are not tracked from this stage
        .mark_addr (3'd0)
    );

    // ********************
    // Datapath
    // ********************

    addr_gen u_agen (
        .clk       (clk),
        .reset     (reset),
        .load      (accept),
        .uop       (uop),
        .base_val  (base_val),
        .index_val (index_val),
        .seg       (seg_val),
        .out       (out)
    );

endmodule

`default_nettype wire

// ==== src/rrag_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decides when a micro-op may leave the stage. A source that is still
// waiting on a writeback, or a held downstream stage, keeps it here.
module rrag_ctrl (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  logic           hold,
    input  rrag_pkg::uop_t uop,
    input  logic           base_pend,
    input  logic           index_pend,
    input  logic           seg_pend,
    output logic           stall,
    output logic           accept,
    output logic           out_valid
);

    import rrag_pkg::*;

    logic base_wait;
    logic index_wait;
    logic seg_wait;
    logic src_wait;

    // ********************
    // Source hazards
    // ********************

    assign base_wait  = uop.use_base & base_pend;
    assign index_wait = uop.use_index & index_pend;
    assign seg_wait   = uop.mem_use & seg_pend;  // Segment only matters for memory
    assign src_wait   = base_wait | index_wait | seg_wait;

    // ********************
    // Stall and accept
    // ********************

    assign stall  = in_valid & (src_wait | hold);
    assign accept = in_valid & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (!hold) begin
            out_valid <= 1'b0;  // Bubble once downstream has taken it
        end
    end

endmodule

`default_nettype wire

// ==== src/addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rrag_defines.svh"

module addr_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load,
    input  rrag_pkg::uop_t          uop,
    input  logic [`RRAG_ADDR_W-1:0] base_val,
    input  logic [`RRAG_ADDR_W-1:0] index_val,
    input  rrag_pkg::seg_ent_t      seg,
    output rrag_pkg::agen_t         out
);

    import rrag_pkg::*;

    logic [`RRAG_ADDR_W-1:0] base_term;
    logic [`RRAG_ADDR_W-1:0] index_term;
    logic [`RRAG_ADDR_W-1:0] offset;
    logic [`RRAG_ADDR_W-1:0] offset_end;
    logic [`RRAG_ADDR_W-1:0] seg_base;
    logic [`RRAG_ADDR_W-1:0] size_m1;
    logic [`RRAG_ADDR_W-1:0] lim_ext;
    agen_t                   nxt;

    // ********************
    // Offset and address
    // ********************

    assign base_term  = uop.use_base ? base_val : '0;
    assign index_term = uop.use_index ? (index_val << uop.scale) : '0;
    assign offset     = base_term + index_term + uop.disp;
    assign seg_base   = {seg.sel, 16'h0000};

    always_comb begin
        case (uop.opsize)
            OPSIZE_1: size_m1 = 32'd0;
            OPSIZE_2: size_m1 = 32'd1;
            OPSIZE_4: size_m1 = 32'd3;
            default:  size_m1 = 32'd7;  // 8 bytes
        endcase
    end

    assign offset_end = offset + size_m1;
    assign lim_ext    = {{(`RRAG_ADDR_W - `RRAG_LIM_W){1'b0}}, seg.lim};

    always_comb begin
        nxt              = '0;
        nxt.mem_addr     = offset + seg_base;
        nxt.mem_addr_end = offset + seg_base + size_m1;
        nxt.lim_fault    = uop.mem_use && (offset_end > lim_ext);
        nxt.mem_use      = uop.mem_use;
        nxt.base_val     = base_val;
        nxt.index_val    = index_val;
        nxt.dest_reg     = uop.dest_reg;
        nxt.dest_ld      = uop.dest_ld;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (load) begin
            out <= nxt;  // Holds otherwise
        end
    end

endmodule

`default_nettype wire

// ==== src/pend_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register file with one pending bit per entry. A set bit means a writeback
// for that entry is still outstanding.
module pend_regfile #(
    parameter int  NUM_ENT = 8,
    parameter type T       = logic [31:0],
    parameter T    RST_VAL = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  rrag_pkg::reg_idx_t rd_addr_a,
    input  rrag_pkg::reg_idx_t rd_addr_b,
    output T                  rd_data_a,
    output T                  rd_data_b,
    output logic              rd_pend_a,
    output logic              rd_pend_b,
    input  logic              wr_en,
    input  rrag_pkg::reg_idx_t wr_addr,
    input  T                  wr_data,
    input  logic              mark_en,
    input  rrag_pkg::reg_idx_t mark_addr
);

    import rrag_pkg::*;

    T                   mem [NUM_ENT];
    logic [NUM_ENT-1:0] pend;

    // ********************
    // Storage
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ENT; i++) begin
                mem[i] <= RST_VAL;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ********************
    // Pending bits
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= '0;
        end else begin
            if (wr_en) begin
                pend[wr_addr] <= 1'b0;  // Writeback retires the wait
            end
            if (mark_en) begin
                pend[mark_addr] <= 1'b1;  // Later assignment, mark wins
            end
        end
    end

    // Combinational reads, a same-cycle writeback is seen next cycle
    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];
    assign rd_pend_a = pend[rd_addr_a];
    assign rd_pend_b = pend[rd_addr_b];

endmodule

`default_nettype wire

// ==== src/rrag_pkg.sv ====
`default_nettype none

`include "rrag_defines.svh"

package rrag_pkg;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [1:0] {
        OPSIZE_1 = 2'd0,
        OPSIZE_2 = 2'd1,
        OPSIZE_4 = 2'd2,
        OPSIZE_8 = 2'd3
    } opsize_t;

    // ********************
    // Payload types
    // ********************

    typedef struct packed {
        logic [15:0]            sel;  // Selector, base is sel << 16
        logic [`RRAG_LIM_W-1:0] lim;
    } seg_ent_t;

    typedef struct packed {
        reg_idx_t                base_reg;
        logic                    use_base;
        reg_idx_t                index_reg;
        logic                    use_index;
        logic [1:0]              scale;     // Index shift amount
        reg_idx_t                seg_reg;
        logic                    mem_use;
        logic [`RRAG_ADDR_W-1:0] disp;
        opsize_t                 opsize;
        reg_idx_t                dest_reg;
        logic                    dest_ld;   // Marks dest_reg pending on accept
    } uop_t;

    typedef struct packed {
        logic                    gpr_ld;
        reg_idx_t                gpr_addr;
        logic [`RRAG_ADDR_W-1:0] gpr_data;
        logic                    seg_ld;
        reg_idx_t                seg_addr;
        seg_ent_t                seg_data;
    } wb_t;

    typedef struct packed {
        logic [`RRAG_ADDR_W-1:0] mem_addr;
        logic [`RRAG_ADDR_W-1:0] mem_addr_end;  // Last byte of the access
        logic                    lim_fault;
        logic                    mem_use;
        logic [`RRAG_ADDR_W-1:0] base_val;
        logic [`RRAG_ADDR_W-1:0] index_val;
        reg_idx_t                dest_reg;
        logic                    dest_ld;
    } agen_t;

endpackage

`default_nettype wire

// ==== src/rrag_defines.svh ====
`ifndef RRAG_DEFINES_SVH
`define RRAG_DEFINES_SVH

// ********************
// Register file sizes
// ********************

`define RRAG_NUM_GPR 8
`define RRAG_NUM_SEG 8

// ********************
// Address and limits
// ********************

`define RRAG_ADDR_W 32
`define RRAG_LIM_W 20

// Flat 1 MB segment limit out of reset
`define RRAG_RESET_LIM {`RRAG_LIM_W{1'b1}}

`endif
